/* hw/menu_rom.mem */
// menu rom image for $readmemh, one hex byte per entry
// @ lines give the byte address, unlisted bytes read as zero
@000
78 d8
a2 ff
9a a9
00 8d
@3f8
ea 40
10 80
00 80
40 80

/* flist.f */
hw/launcher_pkg.sv
hw/ppu_pkg.sv
hw/cpu_decode.sv
hw/launch_regs.sv
hw/scanline_tracker.sv
hw/menu_rom.sv
hw/cpu_read_mux.sv
hw/launcher_top.sv
tb/tb_launcher.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the launcher testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --top-module tb_launcher -f flist.f \
    --Mdir obj_dir -o tb_launcher_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_launcher_sim
run_status=$?
if [ $run_status -ne 0 ]; then
    echo "simulation returned status $run_status"
    exit $run_status
fi

exit 0

/* tb/tb_launcher.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_launcher;

    logic        bus;
    logic        rst_n;
    logic [3:0]  ctrl;
    logic [15:0] cpu_addr;
    logic        cpu_rw;
    logic        cpu_strobe;
    logic [7:0]  cpu_data_in;
    logic [7:0]  st_rec_data;
    logic [13:0] ppu_addr;
    logic        ppu_rd_strobe;
    logic [7:0]  cpu_data_out;
    logic        custom_cpu_out;
    logic        prg_oe;
    logic        prg_we;
    logic [14:0] prg_addr;
    logic        status;
    logic [8:0]  st_rec_addr;
    logic [14:0] chr_addr;
    logic        ciram_ce;

    // stimulus table, one entry per strobe
    string       t_name [$];
    bit          t_ppu [$];
    logic [15:0] t_addr [$];
    bit          t_rw [$];
    logic [7:0]  t_data [$];
    logic [3:0]  t_ctrl [$];
    bit          t_chk [$];
    logic [15:0] t_exp [$];
    bit          rows_ready = 1'b0;

    logic [7:0]  rom_copy [1024];
    integer      seed;

    // reference state of the register block
    logic        m_status;
    logic [14:0] m_prg;
    logic        m_toggle;
    logic        m_pending;
    logic [8:0]  m_rec;

    launcher_top u_dut (
        .bus            (bus),
        .rst_n          (rst_n),
        .ctrl           (ctrl),
        .cpu_addr       (cpu_addr),
        .cpu_rw         (cpu_rw),
        .cpu_strobe     (cpu_strobe),
        .cpu_data_in    (cpu_data_in),
        .st_rec_data    (st_rec_data),
        .ppu_addr       (ppu_addr),
        .ppu_rd_strobe  (ppu_rd_strobe),
        .cpu_data_out   (cpu_data_out),
        .custom_cpu_out (custom_cpu_out),
        .prg_oe         (prg_oe),
        .prg_we         (prg_we),
        .prg_addr       (prg_addr),
        .status         (status),
        .st_rec_addr    (st_rec_addr),
        .chr_addr       (chr_addr),
        .ciram_ce       (ciram_ce)
    );

    initial begin
        bus = 1'b0;
        forever #20 bus = !bus;
    end

    // every row takes three cycles, so this leaves plenty of margin
    initial begin
        wait (rows_ready);
        repeat (t_name.size() * 4 + 100) @(posedge bus);
        $display("timeout: the stimulus table did not finish in time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value check stopped the run");
        end
    endtask

    task automatic add_row(input string name, input bit ppu, input logic [15:0] addr,
                           input bit rw, input logic [7:0] data, input logic [3:0] c,
                           input bit chk, input logic [15:0] exp);
        t_name.push_back(name);
        t_ppu.push_back(ppu);
        t_addr.push_back(addr);
        t_rw.push_back(rw);
        t_data.push_back(data);
        t_ctrl.push_back(c);
        t_chk.push_back(chk);
        t_exp.push_back(exp);
    endtask

    // chr address with chr_hi set, the bank, then the low 12 ppu address bits
    function automatic logic [15:0] chr_expect(input logic [15:0] a, input logic [1:0] bank);
        return {2'b01, bank, a[11:0]};
    endfunction

    task automatic build_table();
        logic [1:0]  bank;
        logic [15:0] a;
        seed = 86523;
        add_row("status_set", 1'b0, 16'h5001, 1'b0, 8'h02, 4'h0, 1'b0, 16'h0000);
        add_row("prg_lo", 1'b0, 16'h5002, 1'b0, 8'h34, 4'h0, 1'b0, 16'h0000);
        add_row("prg_hi", 1'b0, 16'h5002, 1'b0, 8'h92, 4'h0, 1'b0, 16'h0000);
        add_row("prg_data_rd", 1'b0, 16'h5003, 1'b1, 8'h00, 4'h0, 1'b0, 16'h0000);
        add_row("prg_data_wr", 1'b0, 16'h5003, 1'b0, 8'h5a, 4'h0, 1'b0, 16'h0000);
        add_row("ctrl_rd", 1'b0, 16'h5000, 1'b1, 8'h00, 4'h6, 1'b1, 16'h0003);
        add_row("hook_lo", 1'b0, 16'hfffa, 1'b1, 8'h00, 4'h8, 1'b1, 16'h0000);
        add_row("hook_hi", 1'b0, 16'hfffb, 1'b1, 8'h00, 4'h8, 1'b1, 16'h00fc);
        // recorder byte is the inverted low pointer byte
        add_row("rec_rd0", 1'b0, 16'h5004, 1'b1, 8'h00, 4'h0, 1'b1, 16'h00ff);
        add_row("rec_rd1", 1'b0, 16'h5004, 1'b1, 8'h00, 4'h0, 1'b1, 16'h00fe);
        add_row("rec_wr", 1'b0, 16'h5004, 1'b0, 8'h77, 4'h0, 1'b0, 16'h0000);
        add_row("rec_rd2", 1'b0, 16'h5004, 1'b1, 8'h00, 4'h0, 1'b1, 16'h00ff);
        add_row("ctrl_rd2", 1'b0, 16'h5000, 1'b1, 8'h00, 4'hc, 1'b1, 16'h0002);
        add_row("plain_lo", 1'b0, 16'hfffa, 1'b1, 8'h00, 4'h0, 1'b1, {8'h00, rom_copy[10'h3fa]});
        add_row("plain_hi", 1'b0, 16'hfffb, 1'b1, 8'h00, 4'h0, 1'b1, {8'h00, rom_copy[10'h3fb]});
        add_row("rom_0", 1'b0, 16'h8000, 1'b1, 8'h00, 4'h0, 1'b1, {8'h00, rom_copy[10'h000]});
        add_row("rom_5", 1'b0, 16'h8005, 1'b1, 8'h00, 4'h0, 1'b1, {8'h00, rom_copy[10'h005]});
        add_row("rom_mirror", 1'b0, 16'hc3f9, 1'b1, 8'h00, 4'h0, 1'b1, {8'h00, rom_copy[10'h3f9]});
        add_row("rom_3ff", 1'b0, 16'h83ff, 1'b1, 8'h00, 4'h0, 1'b1, {8'h00, rom_copy[10'h3ff]});
        // half of the filler lands in the register window
        for (int k = 0; k < 12; k++) begin
            if (k % 2 == 0) begin
                a = 16'h5000 + 16'($random(seed) & 7);
            end else begin
                a = 16'($random(seed));
            end
            add_row($sformatf("random%0d", k), 1'b0, a, 1'($random(seed)),
                    8'($random(seed)), 4'h0, 1'b0, 16'h0000);
        end
        add_row("vblank_set", 1'b0, 16'h5001, 1'b0, 8'h01, 4'h1, 1'b0, 16'h0000);
        add_row("vblank_end", 1'b0, 16'h5000, 1'b1, 8'h00, 4'h1, 1'b1, 16'h0000);
        bank = 2'b00;
        for (int ln = 0; ln < 65; ln++) begin
            // mirror read then pattern read, one fall of bit 13 per tile
            for (int t = 0; t < 40; t++) begin
                a = 16'(16'h3000 + t);
                add_row($sformatf("line%0d_mirror%0d", ln, t), 1'b1, a, 1'b1, 8'h00,
                        4'h1, 1'b1, chr_expect(a, bank));
                a = 16'(t * 16);
                add_row($sformatf("line%0d_pattern%0d", ln, t), 1'b1, a, 1'b1, 8'h00,
                        4'h1, 1'b1, chr_expect(a, bank));
            end
            if (ln == 64) begin
                // 64 lines counted, so the rise at tile 40 moves the bank
                bank = 2'b01;
                add_row("bank_switch", 1'b1, 16'h2000, 1'b1, 8'h00, 4'h1, 1'b1,
                        chr_expect(16'h2000, bank));
            end else begin
                for (int n = 0; n < 4; n++) begin
                    a = 16'(16'h2000 + n);
                    add_row($sformatf("line%0d_nt%0d", ln, n), 1'b1, a, 1'b1, 8'h00,
                            4'h1, 1'b1, chr_expect(a, bank));
                end
            end
        end
        rows_ready = 1'b1;
    endtask

    task automatic update_model(input logic [15:0] a, input bit rw, input logic [7:0] d,
                                input logic [3:0] c);
        bit rearm;
        rearm = rw && c[3] && (a == 16'hfffa);
        if (!rw && a == 16'h5001) begin
            m_status = d[1];
        end
        if (rearm) begin
            m_toggle  = 1'b0;
            m_pending = 1'b0;
            m_prg     = 15'h0000;
        end else if (!rw && a == 16'h5002) begin
            if (m_toggle) begin
                m_prg[14:8] = d[6:0];
            end else begin
                m_prg[7:0] = d;
            end
            m_toggle  = !m_toggle;
            m_pending = 1'b0;
        end else begin
            if (m_pending) begin
                m_prg = m_prg + 1'b1;
            end
            m_pending = (a == 16'h5003);
        end
        if (rearm) begin
            m_rec = 9'h100;
        end else if (a == 16'h5004) begin
            m_rec = rw ? m_rec + 1'b1 : 9'h100;
        end
    endtask

    task automatic apply_row(input int i);
        string       nm;
        logic [15:0] a;
        bit          rw;
        logic        exp_oe;
        nm = t_name[i];
        a  = t_addr[i];
        rw = t_rw[i];
        @(posedge bus);
        #2;
        ctrl = t_ctrl[i];
        if (t_ppu[i]) begin
            ppu_addr = a[13:0];
        end else begin
            cpu_addr    = a;
            cpu_rw      = rw;
            cpu_data_in = t_data[i];
            st_rec_data = ~m_rec[7:0];
        end
        @(posedge bus);
        #2;
        if (t_ppu[i]) begin
            ppu_rd_strobe = 1'b1;
        end else begin
            cpu_strobe = 1'b1;
        end
        @(posedge bus);
        #2;
        ppu_rd_strobe = 1'b0;
        cpu_strobe    = 1'b0;
        if (t_ppu[i]) begin
            check({nm, ".chr_addr"}, 32'(t_exp[i]), 32'(chr_addr));
            check({nm, ".ciram_ce"}, 32'(!a[13]), 32'(ciram_ce));
        end else begin
            update_model(a, rw, t_data[i], t_ctrl[i]);
            exp_oe = rw && (a[15] || a == 16'h5000 || a == 16'h5003 || a == 16'h5004);
            check({nm, ".prg_oe"}, 32'(exp_oe), 32'(prg_oe));
            check({nm, ".prg_we"}, 32'(!rw && a == 16'h5003), 32'(prg_we));
            check({nm, ".custom"}, 32'(!(a == 16'h5003 || a == 16'h5004)), 32'(custom_cpu_out));
            check({nm, ".status"}, 32'(m_status), 32'(status));
            check({nm, ".prg_addr"}, 32'(m_prg), 32'(prg_addr));
            check({nm, ".st_rec_addr"}, 32'(m_rec), 32'(st_rec_addr));
            if (t_chk[i]) begin
                check({nm, ".data"}, 32'(t_exp[i]), 32'(cpu_data_out));
            end
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        ctrl          = 4'h0;
        cpu_addr      = 16'h0000;
        cpu_rw        = 1'b1;
        cpu_strobe    = 1'b0;
        cpu_data_in   = 8'h00;
        st_rec_data   = 8'h00;
        ppu_addr      = 14'h0000;
        ppu_rd_strobe = 1'b0;
        m_status      = 1'b0;
        m_prg         = 15'h0000;
        m_toggle      = 1'b0;
        m_pending     = 1'b0;
        m_rec         = 9'h000;
        for (int k = 0; k < 1024; k++) begin
            rom_copy[k] = 8'h00;
        end
        $readmemh("hw/menu_rom.mem", rom_copy);
        build_table();
        repeat (2) @(posedge bus);
        #2;
        rst_n = 1'b1;
        @(posedge bus);
        #2;
        check("reset.status", 32'h0, 32'(status));
        check("reset.prg_addr", 32'h0, 32'(prg_addr));
        check("reset.st_rec_addr", 32'h0, 32'(st_rec_addr));
        check("reset.chr_addr", 32'h0, 32'(chr_addr));
        check("reset.ciram_ce", 32'h1, 32'(ciram_ce));
        for (int i = 0; i < t_name.size(); i++) begin
            apply_row(i);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/launcher_top.sv */
`timescale 1ns/1ps
`default_nettype none

module launcher_top (
    input  wire logic                    bus,
    input  wire logic                    rst_n,
    input  wire launcher_pkg::ctrl_t     ctrl,
    input  wire launcher_pkg::cpu_addr_t cpu_addr,
    input  wire logic                    cpu_rw,
    input  wire logic                    cpu_strobe,
    input  wire launcher_pkg::cpu_data_t cpu_data_in,
    input  wire launcher_pkg::cpu_data_t st_rec_data,
    input  wire ppu_pkg::ppu_addr_t      ppu_addr,
    input  wire logic                    ppu_rd_strobe,
    output launcher_pkg::cpu_data_t      cpu_data_out,
    output logic                         custom_cpu_out,
    output logic                         prg_oe,
    output logic                         prg_we,
    output launcher_pkg::prg_addr_t      prg_addr,
    output logic                         status,
    output launcher_pkg::rec_addr_t      st_rec_addr,
    output ppu_pkg::chr_addr_t           chr_addr,
    output logic                         ciram_ce
);

    logic sel_ctrl;
    logic sel_status;
    logic sel_prg_addr;
    logic sel_prg_data;
    logic sel_rec;
    logic sel_vec_lo;
    logic sel_vec_hi;
    logic vblank;
    launcher_pkg::cpu_data_t rom_q;

    cpu_decode u_decode (
        .cpu_addr       (cpu_addr),
        .cpu_rw         (cpu_rw),
        .nmi_hook       (ctrl[3]),
        .sel_ctrl       (sel_ctrl),
        .sel_status     (sel_status),
        .sel_prg_addr   (sel_prg_addr),
        .sel_prg_data   (sel_prg_data),
        .sel_rec        (sel_rec),
        .sel_vec_lo     (sel_vec_lo),
        .sel_vec_hi     (sel_vec_hi),
        // the read mux falls back to rom_q without a select
        .sel_rom        (),
        .prg_oe         (prg_oe),
        .prg_we         (prg_we),
        .custom_cpu_out (custom_cpu_out)
    );

    launch_regs u_regs (
        .bus          (bus),
        .rst_n        (rst_n),
        .cpu_strobe   (cpu_strobe),
        .cpu_rw       (cpu_rw),
        .cpu_data_in  (cpu_data_in),
        .sel_status   (sel_status),
        .sel_prg_addr (sel_prg_addr),
        .sel_prg_data (sel_prg_data),
        .sel_rec      (sel_rec),
        .sel_vec_lo   (sel_vec_lo),
        .status       (status),
        .vblank       (vblank),
        .prg_addr     (prg_addr),
        .st_rec_addr  (st_rec_addr)
    );

    scanline_tracker u_tracker (
        .bus           (bus),
        .rst_n         (rst_n),
        .vblank        (vblank),
        .ppu_rd_strobe (ppu_rd_strobe),
        .ppu_addr      (ppu_addr),
        .chr_hi        (ctrl[0]),
        .chr_addr      (chr_addr),
        .ciram_ce      (ciram_ce)
    );

    menu_rom u_rom (
        .bus        (bus),
        .rst_n      (rst_n),
        .cpu_strobe (cpu_strobe),
        .cpu_rw     (cpu_rw),
        .rom_addr   (cpu_addr[9:0]),
        .rom_q      (rom_q)
    );

    cpu_read_mux u_mux (
        .sel_ctrl     (sel_ctrl),
        .sel_rec      (sel_rec),
        .sel_vec_lo   (sel_vec_lo),
        .sel_vec_hi   (sel_vec_hi),
        .ctrl_bits    (ctrl[2:1]),
        .st_rec_data  (st_rec_data),
        .rom_q        (rom_q),
        .cpu_data_out (cpu_data_out)
    );

endmodule

`default_nettype wire

/* hw/cpu_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_read_mux (
    input  wire logic                    sel_ctrl,
    input  wire logic                    sel_rec,
    input  wire logic                    sel_vec_lo,
    input  wire logic                    sel_vec_hi,
    input  wire logic [1:0]              ctrl_bits,
    input  wire launcher_pkg::cpu_data_t st_rec_data,
    input  wire launcher_pkg::cpu_data_t rom_q,
    output launcher_pkg::cpu_data_t      cpu_data_out
);

    // rom_q unless one of the register or vector selects is active
    always_comb begin
        if (sel_ctrl) begin
            cpu_data_out = {6'b0, ctrl_bits};
        end else if (sel_rec) begin
            // recorder byte straight from the external state recorder
            cpu_data_out = st_rec_data;
        end else if (sel_vec_lo) begin
            cpu_data_out = launcher_pkg::MENU_VEC_LO;
        end else if (sel_vec_hi) begin
            cpu_data_out = launcher_pkg::MENU_VEC_HI;
        end else begin
            cpu_data_out = rom_q;
        end
    end

endmodule

`default_nettype wire

/* hw/menu_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module menu_rom (
    input  wire logic                                     bus,
    input  wire logic                                     rst_n,
    input  wire logic                                     cpu_strobe,
    input  wire logic                                     cpu_rw,
    input  wire logic [launcher_pkg::ROM_ADDR_BITS-1:0]   rom_addr,
    output launcher_pkg::cpu_data_t                       rom_q
);

    launcher_pkg::cpu_data_t rom [launcher_pkg::ROM_DEPTH];

    initial begin
        $readmemh("hw/menu_rom.mem", rom);
    end

    // output register, updated on cpu reads only
    always_ff @(posedge bus or negedge rst_n) begin
        if (!rst_n) begin
            rom_q <= '0;
        end else if (cpu_strobe && cpu_rw) begin
            rom_q <= rom[rom_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/scanline_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module scanline_tracker (
    input  wire logic               bus,
    input  wire logic               rst_n,
    input  wire logic               vblank,
    input  wire logic               ppu_rd_strobe,
    input  wire ppu_pkg::ppu_addr_t ppu_addr,
    input  wire logic               chr_hi,
    output ppu_pkg::chr_addr_t      chr_addr,
    output logic                    ciram_ce
);

    ppu_pkg::scanline_t  scanline_cnt;
    ppu_pkg::tile_cnt_t  tile_cnt;
    ppu_pkg::match_cnt_t match_cnt;
    ppu_pkg::chr_bank_t  chr_bank;
    logic                last_a13;
    logic                nt_read;
    logic                a13_rise;
    logic                a13_fall;

    assign nt_read  = (ppu_addr[13:12] == 2'b10);
    assign a13_rise = !last_a13 && ppu_addr[13];
    assign a13_fall = last_a13 && !ppu_addr[13];

    // bit 13 of the previous read, kept through vblank
    always_ff @(posedge bus or negedge rst_n) begin
        if (!rst_n) begin
            last_a13 <= 1'b0;
        end else if (ppu_rd_strobe) begin
            last_a13 <= ppu_addr[13];
        end
    end

    always_ff @(posedge bus or negedge rst_n) begin
        if (!rst_n) begin
            scanline_cnt <= '0;
            tile_cnt     <= '0;
            match_cnt    <= '0;
            chr_bank     <= '0;
        end else if (vblank) begin
            scanline_cnt <= '0;
            tile_cnt     <= '0;
            match_cnt    <= '0;
            chr_bank     <= '0;
        end else if (ppu_rd_strobe) begin
            // a run of name table reads marks the end of a line
            if (nt_read) begin
                if (match_cnt == ppu_pkg::NT_MATCH_RUN) begin
                    scanline_cnt <= scanline_cnt + 1'b1;
                    tile_cnt     <= '0;
                end else begin
                    match_cnt <= match_cnt + 1'b1;
                end
            end else begin
                match_cnt <= '0;
            end

            if (a13_fall) begin
                tile_cnt <= tile_cnt + 1'b1;
            end

            // switch ahead of the next line's first two tiles, every 64 lines
            if (a13_rise && tile_cnt == ppu_pkg::BANK_SWITCH_TILE &&
                scanline_cnt[5:0] == 6'd0) begin
                chr_bank <= scanline_cnt[7:6];
            end
        end
    end

    assign chr_addr = {chr_hi, chr_bank, ppu_addr[11:0]};
    assign ciram_ce = !ppu_addr[13];

endmodule

`default_nettype wire

/* hw/launch_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module launch_regs (
    input  wire logic                    bus,
    input  wire logic                    rst_n,
    input  wire logic                    cpu_strobe,
    input  wire logic                    cpu_rw,
    input  wire launcher_pkg::cpu_data_t cpu_data_in,
    input  wire logic                    sel_status,
    input  wire logic                    sel_prg_addr,
    input  wire logic                    sel_prg_data,
    input  wire logic                    sel_rec,
    input  wire logic                    sel_vec_lo,
    output logic                         status,
    output logic                         vblank,
    output launcher_pkg::prg_addr_t      prg_addr,
    output launcher_pkg::rec_addr_t      st_rec_addr
);

    logic addr_toggle;
    logic inc_pending;
    logic rearm;

    // hooked nmi fetch restarts the save-state sequence
    assign rearm = cpu_rw && sel_vec_lo;

    always_ff @(posedge bus or negedge rst_n) begin
        if (!rst_n) begin
            status      <= 1'b0;
            vblank      <= 1'b1;
            addr_toggle <= 1'b0;
            inc_pending <= 1'b0;
            prg_addr    <= '0;
            st_rec_addr <= '0;
        end else if (cpu_strobe) begin
            // status and vblank
            if (!cpu_rw && sel_status) begin
                {status, vblank} <= cpu_data_in[1:0];
            end else begin
                vblank <= 1'b0;
            end

            // prg address, loaded low byte first
            if (rearm) begin
                addr_toggle <= 1'b0;
                inc_pending <= 1'b0;
                prg_addr    <= '0;
            end else if (!cpu_rw && sel_prg_addr) begin
                if (addr_toggle) begin
                    prg_addr[14:8] <= cpu_data_in[6:0];
                end else begin
                    prg_addr[7:0] <= cpu_data_in;
                end
                addr_toggle <= !addr_toggle;
                inc_pending <= 1'b0;
            end else begin
                // data port access bumps the address one strobe later
                if (inc_pending) begin
                    prg_addr <= prg_addr + 1'b1;
                end
                inc_pending <= sel_prg_data;
            end

            // recorder readout pointer
            if (rearm) begin
                st_rec_addr <= launcher_pkg::REC_START;
            end else if (sel_rec) begin
                if (cpu_rw) begin
                    st_rec_addr <= st_rec_addr + 1'b1;
                end else begin
                    st_rec_addr <= launcher_pkg::REC_START;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/cpu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
    input  wire launcher_pkg::cpu_addr_t cpu_addr,
    input  wire logic                    cpu_rw,
    input  wire logic                    nmi_hook,
    output logic                         sel_ctrl,
    output logic                         sel_status,
    output logic                         sel_prg_addr,
    output logic                         sel_prg_data,
    output logic                         sel_rec,
    output logic                         sel_vec_lo,
    output logic                         sel_vec_hi,
    output logic                         sel_rom,
    output logic                         prg_oe,
    output logic                         prg_we,
    output logic                         custom_cpu_out
);

    // register window
    assign sel_ctrl     = (cpu_addr == launcher_pkg::REG_CTRL);
    assign sel_status   = (cpu_addr == launcher_pkg::REG_STATUS);
    assign sel_prg_addr = (cpu_addr == launcher_pkg::REG_PRG_ADDR);
    assign sel_prg_data = (cpu_addr == launcher_pkg::REG_PRG_DATA);
    assign sel_rec      = (cpu_addr == launcher_pkg::REG_REC_DATA);

    // vectors only count as hooked while the hook is on
    assign sel_vec_lo = nmi_hook && (cpu_addr == launcher_pkg::NMI_VEC_LO);
    assign sel_vec_hi = nmi_hook && (cpu_addr == launcher_pkg::NMI_VEC_HI);

    // anything not claimed above reads from the menu rom
    assign sel_rom = !(sel_ctrl || sel_status || sel_prg_addr || sel_prg_data ||
                       sel_rec || sel_vec_lo || sel_vec_hi);

    // prg memory drives the bus for rom space and the data-carrying registers
    assign prg_oe = cpu_rw && (cpu_addr[15] || sel_ctrl || sel_prg_data || sel_rec);
    assign prg_we = !cpu_rw && sel_prg_data;

    // 0x5003 and 0x5004 data comes from outside the mapper
    assign custom_cpu_out = !(sel_prg_data || sel_rec);

endmodule

`default_nettype wire

/* hw/ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

    typedef logic [13:0] ppu_addr_t;
    typedef logic [14:0] chr_addr_t;
    typedef logic [1:0]  chr_bank_t;
    typedef logic [7:0]  scanline_t;
    typedef logic [5:0]  tile_cnt_t;
    typedef logic [1:0]  match_cnt_t;

    // name table reads in a row before a scanline is counted
    localparam match_cnt_t NT_MATCH_RUN = 2'd3;
    // tile count at which the next line's first fetches begin
    localparam tile_cnt_t BANK_SWITCH_TILE = 6'd40;

endpackage

`default_nettype wire

/* hw/launcher_pkg.sv */
`default_nettype none

package launcher_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [14:0] prg_addr_t;
    typedef logic [8:0]  rec_addr_t;
    // bit 0 chr high, bits 2:1 readable, bit 3 nmi hook
    typedef logic [3:0]  ctrl_t;

    // register window
    localparam cpu_addr_t REG_CTRL     = 16'h5000;
    localparam cpu_addr_t REG_STATUS   = 16'h5001;
    localparam cpu_addr_t REG_PRG_ADDR = 16'h5002;
    localparam cpu_addr_t REG_PRG_DATA = 16'h5003;
    localparam cpu_addr_t REG_REC_DATA = 16'h5004;

    localparam cpu_addr_t NMI_VEC_LO = 16'hFFFA;
    localparam cpu_addr_t NMI_VEC_HI = 16'hFFFB;

    // hooked nmi lands at 0xfc00
    localparam cpu_data_t MENU_VEC_LO = 8'h00;
    localparam cpu_data_t MENU_VEC_HI = 8'hFC;

    localparam rec_addr_t REC_START = 9'h100;

    localparam int ROM_DEPTH     = 1024;
    localparam int ROM_ADDR_BITS = 10;

endpackage

`default_nettype wire
